// ==== design/alu_pkg.sv ====
package alu_pkg;

   // datapath
   localparam int word_w = 64;                 // full mmx-wide operand
   typedef logic [word_w-1:0] alu_word_t;

   // flag vector, same bit order as the core's eflags bus
   localparam int flag_w = 6;
   typedef logic [flag_w-1:0] eflags_t;

   localparam int flag_of = 5;
   localparam int flag_sf = 4;
   localparam int flag_zf = 3;
   localparam int flag_af = 2;
   localparam int flag_cf = 1;
   localparam int flag_pf = 0;                 // filled in by the result stage

   // shifts only honour the low count bits, as on a 32-bit x86
   localparam int shift_count_w = 5;

   // packed lanes
   localparam int lane16_n = 4;
   localparam int lane32_n = 2;
   localparam int lane16_w = word_w / lane16_n;
   localparam int lane32_w = word_w / lane32_n;

   // alu_op codes from decode, 3/5/14 left unused
   typedef enum logic [3:0] {
      alu_pass   = 4'd0,
      alu_add    = 4'd1,
      alu_and    = 4'd2,
      alu_mov    = 4'd4,
      alu_cmovc  = 4'd6,   // old jmp slot
      alu_not    = 4'd7,
      alu_or     = 4'd8,
      alu_paddw  = 4'd9,
      alu_paddd  = 4'd10,
      alu_pmaxsw = 4'd11,
      alu_sal    = 4'd12,
      alu_sar    = 4'd13,
      alu_pminsw = 4'd15   // spare code
   } alu_op_e;

   // operand size from decode, anything else is unsupported
   typedef enum logic [2:0] {
      ops_8  = 3'd1,
      ops_16 = 3'd2,
      ops_32 = 3'd3
   } opsize_e;

   // what one execution unit hands to the result stage
   typedef struct packed {
      alu_word_t result;   // zero-extended
      eflags_t   flags;    // only bits in mask may be set
      eflags_t   mask;     // flags this op writes
   } alu_result_t;

endpackage

// ==== design/alu_operand_if.sv ====
`timescale 1ns/1ps

// operands shared by the scalar, shift and packed units
interface alu_operand_if;

   alu_pkg::alu_word_t a;           // destination operand
   alu_pkg::alu_word_t b;           // source operand / shift count
   alu_pkg::opsize_e   opsize;
   alu_pkg::eflags_t   eflags_in;   // current flags, cmovc reads cf

   modport top_drv (
      output a, b, opsize, eflags_in
   );

   modport unit_src (
      input a, b, opsize, eflags_in
   );

endinterface

// ==== design/alu_scalar_unit.sv ====
`timescale 1ns/1ps

module alu_scalar_unit (
   alu_operand_if.unit_src        operands,
   input  alu_pkg::alu_op_e       alu_op,
   output alu_pkg::alu_result_t   res
);

   logic [31:0] size_mask;    // keeps the active operand bytes
   logic [4:0]  msb_idx;      // sign bit of the sized result
   logic [5:0]  carry_idx;    // carry-out position of the sized add
   logic        size_ok;

   logic [31:0] a_m;
   logic [31:0] b_m;
   logic [32:0] sum33;
   logic [31:0] sum_r;
   logic        add_cf;
   logic        add_af;
   logic        add_of;

   // operand size decode
   always_comb begin
      size_ok   = 1'b1;
      size_mask = 32'hffff_ffff;
      msb_idx   = 5'd31;
      carry_idx = 6'd32;
      case (operands.opsize)
         alu_pkg::ops_8: begin
            size_mask = 32'h0000_00ff;
            msb_idx   = 5'd7;
            carry_idx = 6'd8;
         end
         alu_pkg::ops_16: begin
            size_mask = 32'h0000_ffff;
            msb_idx   = 5'd15;
            carry_idx = 6'd16;
         end
         alu_pkg::ops_32: ;               // defaults above
         default: begin
            size_ok   = 1'b0;             // result forced to zero below
            size_mask = '0;
         end
      endcase
   end

   assign a_m = operands.a[31:0] & size_mask;
   assign b_m = operands.b[31:0] & size_mask;

   // one 33-bit adder serves all three sizes, upper bits are zero
   assign sum33  = {1'b0, a_m} + {1'b0, b_m};
   assign sum_r  = sum33[31:0] & size_mask;   // drop the carry for 8/16
   assign add_cf = sum33[carry_idx];
   assign add_af = a_m[4] ^ b_m[4] ^ sum33[4];  // carry into bit 4
   // same-sign operands giving opposite-sign sum
   assign add_of = (a_m[msb_idx] == b_m[msb_idx]) && (sum33[msb_idx] != a_m[msb_idx]);

   always_comb begin
      res = '0;
      case (alu_op)
         alu_pkg::alu_add: begin
            res.result                  = {32'b0, sum_r};
            res.mask                    = '1;
            res.flags[alu_pkg::flag_of] = add_of;
            res.flags[alu_pkg::flag_af] = add_af;
            res.flags[alu_pkg::flag_cf] = add_cf;
         end
         alu_pkg::alu_and, alu_pkg::alu_or: begin
            res.result = (alu_op == alu_pkg::alu_and) ? {32'b0, a_m & b_m}
                                                      : {32'b0, a_m | b_m};
            res.mask   = '1;
            res.mask[alu_pkg::flag_af] = 1'b0;     // af left alone, of/cf cleared
         end
         alu_pkg::alu_not: res.result = {32'b0, ~a_m & size_mask};   // no flags
         alu_pkg::alu_pass: res.result = operands.a;
         alu_pkg::alu_mov: res.result = operands.b;
         alu_pkg::alu_cmovc: begin
            // move only when cf is set, else keep destination
            res.result = operands.eflags_in[alu_pkg::flag_cf] ? operands.b : operands.a;
         end
         default: ;
      endcase

      // sf/zf from the sized result wherever the op writes them
      if (res.mask[alu_pkg::flag_sf])
         res.flags[alu_pkg::flag_sf] = res.result[msb_idx];
      if (res.mask[alu_pkg::flag_zf])
         res.flags[alu_pkg::flag_zf] = (res.result == '0);

      if (!size_ok)
         res = '0;
   end

endmodule

// ==== design/alu_shift_unit.sv ====
`timescale 1ns/1ps

module alu_shift_unit (
   alu_operand_if.unit_src        operands,
   input  alu_pkg::alu_op_e       alu_op,
   output alu_pkg::alu_result_t   res
);

   logic [alu_pkg::shift_count_w-1:0] count;   // upper count bits ignored
   logic [31:0]        a32;
   logic [32:0]        sal_wide;   // bit 32 catches the last bit out
   logic signed [32:0] sar_wide;   // bit 0 catches the last bit out
   logic [31:0]        shf_r;
   logic               shf_cf;
   logic               is_shift;

   assign count = operands.b[alu_pkg::shift_count_w-1:0];
   assign a32   = operands.a[31:0];

   assign sal_wide = {1'b0, a32} << count;
   assign sar_wide = $signed({a32, 1'b0}) >>> count;

   assign is_shift = (alu_op == alu_pkg::alu_sal) || (alu_op == alu_pkg::alu_sar);
   assign shf_r    = (alu_op == alu_pkg::alu_sal) ? sal_wide[31:0] : sar_wide[32:1];
   assign shf_cf   = (alu_op == alu_pkg::alu_sal) ? sal_wide[32] : sar_wide[0];

   always_comb begin
      res = '0;
      if (is_shift) begin
         res.result = {32'b0, shf_r};   // count 0 leaves a unchanged
         if (count != '0) begin
            res.mask[alu_pkg::flag_sf] = 1'b1;
            res.mask[alu_pkg::flag_zf] = 1'b1;
            res.mask[alu_pkg::flag_cf] = 1'b1;
            res.mask[alu_pkg::flag_pf] = 1'b1;
            res.mask[alu_pkg::flag_of] = (count == 1);   // of defined for 1-bit shifts only

            res.flags[alu_pkg::flag_sf] = shf_r[31];
            res.flags[alu_pkg::flag_zf] = (shf_r == '0);
            res.flags[alu_pkg::flag_cf] = shf_cf;
            // sal: msb xor cf, sar: always 0
            if (count == 1 && alu_op == alu_pkg::alu_sal)
               res.flags[alu_pkg::flag_of] = shf_r[31] ^ shf_cf;
         end
      end
   end

endmodule

// ==== design/alu_packed_unit.sv ====
`timescale 1ns/1ps

module alu_packed_unit (
   alu_operand_if.unit_src        operands,
   input  alu_pkg::alu_op_e       alu_op,
   output alu_pkg::alu_result_t   res
);

   alu_pkg::alu_word_t paddw_r;
   alu_pkg::alu_word_t paddd_r;
   alu_pkg::alu_word_t pmax_r;
   alu_pkg::alu_word_t pmin_r;

   // word lanes, add wraps inside the lane
   for (genvar i = 0; i < alu_pkg::lane16_n; i++) begin : g_lane16
      logic a_gt;   // signed a > b for this lane
      assign a_gt = $signed(operands.a[i*alu_pkg::lane16_w +: alu_pkg::lane16_w]) >
                    $signed(operands.b[i*alu_pkg::lane16_w +: alu_pkg::lane16_w]);
      assign paddw_r[i*alu_pkg::lane16_w +: alu_pkg::lane16_w] =
         operands.a[i*alu_pkg::lane16_w +: alu_pkg::lane16_w] +
         operands.b[i*alu_pkg::lane16_w +: alu_pkg::lane16_w];
      assign pmax_r[i*alu_pkg::lane16_w +: alu_pkg::lane16_w] = a_gt ?
         operands.a[i*alu_pkg::lane16_w +: alu_pkg::lane16_w] :
         operands.b[i*alu_pkg::lane16_w +: alu_pkg::lane16_w];
      assign pmin_r[i*alu_pkg::lane16_w +: alu_pkg::lane16_w] = a_gt ?
         operands.b[i*alu_pkg::lane16_w +: alu_pkg::lane16_w] :
         operands.a[i*alu_pkg::lane16_w +: alu_pkg::lane16_w];
   end

   // dword lanes
   for (genvar j = 0; j < alu_pkg::lane32_n; j++) begin : g_lane32
      assign paddd_r[j*alu_pkg::lane32_w +: alu_pkg::lane32_w] =
         operands.a[j*alu_pkg::lane32_w +: alu_pkg::lane32_w] +
         operands.b[j*alu_pkg::lane32_w +: alu_pkg::lane32_w];
   end

   always_comb begin
      res = '0;   // packed ops never touch flags
      case (alu_op)
         alu_pkg::alu_paddw:  res.result = paddw_r;
         alu_pkg::alu_paddd:  res.result = paddd_r;
         alu_pkg::alu_pmaxsw: res.result = pmax_r;
         alu_pkg::alu_pminsw: res.result = pmin_r;
         default: ;
      endcase
   end

endmodule

// ==== design/alu_result_stage.sv ====
`timescale 1ns/1ps

module alu_result_stage (
   input  logic                   clk,
   input  logic                   rst_n,
   input  alu_pkg::alu_op_e       alu_op,
   input  alu_pkg::alu_result_t   scalar_res,
   input  alu_pkg::alu_result_t   shift_res,
   input  alu_pkg::alu_result_t   packed_res,
   output alu_pkg::alu_word_t     alu_out,
   output alu_pkg::eflags_t       eflags_out,
   output alu_pkg::eflags_t       set_eflags
);

   alu_pkg::alu_result_t sel;

   always_comb begin
      case (alu_op)
         alu_pkg::alu_pass, alu_pkg::alu_add, alu_pkg::alu_and, alu_pkg::alu_mov,
         alu_pkg::alu_cmovc, alu_pkg::alu_not, alu_pkg::alu_or:
            sel = scalar_res;
         alu_pkg::alu_sal, alu_pkg::alu_sar:
            sel = shift_res;
         alu_pkg::alu_paddw, alu_pkg::alu_paddd, alu_pkg::alu_pmaxsw,
         alu_pkg::alu_pminsw:
            sel = packed_res;
         default: sel = '0;   // unused codes retire as a nop
      endcase
      // pf is even parity of the low result byte
      if (sel.mask[alu_pkg::flag_pf])
         sel.flags[alu_pkg::flag_pf] = ~^sel.result[7:0];
   end

   // single output register, one op per cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_out    <= '0;
         eflags_out <= '0;
         set_eflags <= '0;
      end else begin
         alu_out    <= sel.result;
         eflags_out <= sel.flags;
         set_eflags <= sel.mask;
      end
   end

endmodule

// ==== design/x86_alu.sv ====
`timescale 1ns/1ps

module x86_alu (
   input  logic                clk,
   input  logic                rst_n,
   input  alu_pkg::alu_word_t  a,
   input  alu_pkg::alu_word_t  b,
   input  alu_pkg::eflags_t    eflags_in,
   input  alu_pkg::opsize_e    opsize,
   input  alu_pkg::alu_op_e    alu_op,
   output alu_pkg::alu_word_t  alu_out,
   output alu_pkg::eflags_t    eflags_out,
   output alu_pkg::eflags_t    set_eflags
);

   alu_pkg::alu_result_t scalar_res;
   alu_pkg::alu_result_t shift_res;
   alu_pkg::alu_result_t packed_res;

   alu_operand_if operands ();

   // plain ports onto the shared operand bundle
   assign operands.a         = a;
   assign operands.b         = b;
   assign operands.opsize    = opsize;
   assign operands.eflags_in = eflags_in;

   alu_scalar_unit scalar_i (
      .operands (operands),
      .alu_op   (alu_op),
      .res      (scalar_res)
   );

   alu_shift_unit shift_i (
      .operands (operands),
      .alu_op   (alu_op),
      .res      (shift_res)
   );

   alu_packed_unit packed_i (
      .operands (operands),
      .alu_op   (alu_op),
      .res      (packed_res)
   );

   alu_result_stage result_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .alu_op     (alu_op),
      .scalar_res (scalar_res),
      .shift_res  (shift_res),
      .packed_res (packed_res),
      .alu_out    (alu_out),
      .eflags_out (eflags_out),
      .set_eflags (set_eflags)
   );

endmodule

// ==== sim/x86_alu_properties.sv ====
`timescale 1ns/1ps

module x86_alu_props (
   input logic                clk,
   input logic                rst_n,
   input alu_pkg::alu_op_e    alu_op,
   input alu_pkg::alu_word_t  alu_out,
   input alu_pkg::eflags_t    eflags_out,
   input alu_pkg::eflags_t    set_eflags
);

   int unsigned fail_n = 0;   // assertion failure count

   // a reset edge clears all three outputs
   assert property (@(posedge clk) !rst_n |=>
                    (alu_out == '0 && eflags_out == '0 && set_eflags == '0))
      else begin
         $error("outputs not zero in the cycle after a reset edge");
         fail_n++;
      end

   // flag values never leak outside the set mask
   assert property (@(posedge clk) disable iff (!rst_n) (eflags_out & ~set_eflags) == '0)
      else begin
         $error("eflags_out has a bit outside set_eflags");
         fail_n++;
      end

   // packed, not and move ops write no flags
   assert property (@(posedge clk) disable iff (!rst_n)
                    (alu_op inside {alu_pkg::alu_paddw, alu_pkg::alu_paddd, alu_pkg::alu_pmaxsw,
                                    alu_pkg::alu_pminsw, alu_pkg::alu_not, alu_pkg::alu_pass,
                                    alu_pkg::alu_mov, alu_pkg::alu_cmovc})
                    |=> set_eflags == '0)
      else begin
         $error("set_eflags not empty after a flagless op");
         fail_n++;
      end

endmodule

// ==== sim/x86_alu_tb.sv ====
`timescale 1ns/1ps

module x86_alu_tb;

   logic clk;
   logic rst_n;
   alu_pkg::alu_word_t a;
   alu_pkg::alu_word_t b;
   alu_pkg::eflags_t   eflags_in;
   alu_pkg::opsize_e   opsize;
   alu_pkg::alu_op_e   alu_op;
   alu_pkg::alu_word_t alu_out;
   alu_pkg::eflags_t   eflags_out;
   alu_pkg::eflags_t   set_eflags;

   alu_pkg::alu_result_t exp_q[$];   // one entry per op in flight
   string                name_q[$];
   alu_pkg::alu_result_t exp_r;
   string                cur_name;
   int                   due;
   int                   errors = 0;
   int                   checks = 0;
   int                   cycle = 0;
   int                   cycle_limit = 10 + 2100 + 50;   // reset + ops + drain
   integer               seed = 32'h4aff_56cf;
   alu_pkg::alu_op_e     op_list[13];
   alu_pkg::opsize_e     size_list[3];

   x86_alu x86_alu_i (.*);

   bind x86_alu x86_alu_props props_i (
      .clk(clk), .rst_n(rst_n), .alu_op(alu_op),
      .alu_out(alu_out), .eflags_out(eflags_out), .set_eflags(set_eflags)
   );

   always #2 clk = ~clk;   // 4 ns period

   // expected result straight from the x86 flag rules
   function automatic alu_pkg::alu_result_t alu_model(input alu_pkg::alu_op_e op,
         input alu_pkg::opsize_e sz, input alu_pkg::alu_word_t av,
         input alu_pkg::alu_word_t bv, input alu_pkg::eflags_t fv);
      alu_pkg::alu_result_t r;
      alu_pkg::alu_word_t   m;
      alu_pkg::alu_word_t   s;
      int                   n;
      int                   cnt;
      logic [31:0]          v;
      logic                 c;
      logic signed [15:0]   la;
      logic signed [15:0]   lb;
      r   = '0;
      n   = (sz == alu_pkg::ops_8) ? 8 : (sz == alu_pkg::ops_16) ? 16 : 32;
      m   = (64'd1 << n) - 64'd1;
      cnt = bv[4:0];
      v   = av[31:0];
      c   = 1'b0;
      case (op)
         alu_pkg::alu_add: begin
            s        = (av & m) + (bv & m);
            r.result = s & m;
            r.mask   = '1;
            r.flags[alu_pkg::flag_cf] = s[n];
            r.flags[alu_pkg::flag_af] = ({1'b0, av[3:0]} + {1'b0, bv[3:0]}) > 5'd15;
            r.flags[alu_pkg::flag_of] = (av[n-1] == bv[n-1]) && (r.result[n-1] != av[n-1]);
         end
         alu_pkg::alu_and, alu_pkg::alu_or: begin
            r.result = (op == alu_pkg::alu_and) ? (av & bv & m) : ((av | bv) & m);
            r.mask   = 6'b111011;   // everything but af
         end
         alu_pkg::alu_not:   r.result = ~av & m;
         alu_pkg::alu_pass:  r.result = av;
         alu_pkg::alu_mov:   r.result = bv;
         alu_pkg::alu_cmovc: r.result = fv[alu_pkg::flag_cf] ? bv : av;
         alu_pkg::alu_sal, alu_pkg::alu_sar: begin
            for (int i = 0; i < cnt; i++) begin   // one bit at a time
               if (op == alu_pkg::alu_sal) begin
                  c = v[31];
                  v = v << 1;
               end else begin
                  c = v[0];
                  v = {v[31], v[31:1]};
               end
            end
            r.result = {32'b0, v};
            if (cnt != 0) begin
               r.mask  = 6'b011011;               // sf zf cf pf
               r.mask[alu_pkg::flag_of] = (cnt == 1);
               r.flags[alu_pkg::flag_sf] = v[31];
               r.flags[alu_pkg::flag_zf] = (v == 32'b0);
               r.flags[alu_pkg::flag_cf] = c;
               r.flags[alu_pkg::flag_of] = (cnt == 1) && (op == alu_pkg::alu_sal) && (v[31] ^ c);
            end
         end
         alu_pkg::alu_paddd:
            for (int i = 0; i < 2; i++) r.result[i*32 +: 32] = av[i*32 +: 32] + bv[i*32 +: 32];
         default: begin   // word lanes
            for (int i = 0; i < 4; i++) begin
               la = av[i*16 +: 16];
               lb = bv[i*16 +: 16];
               if (op == alu_pkg::alu_paddw)       r.result[i*16 +: 16] = la + lb;
               else if (op == alu_pkg::alu_pmaxsw) r.result[i*16 +: 16] = (la >= lb) ? la : lb;
               else                                r.result[i*16 +: 16] = (la <= lb) ? la : lb;
            end
         end
      endcase
      if (op == alu_pkg::alu_add || op == alu_pkg::alu_and || op == alu_pkg::alu_or) begin
         r.flags[alu_pkg::flag_sf] = r.result[n-1];
         r.flags[alu_pkg::flag_zf] = (r.result == '0);
      end
      if (r.mask[alu_pkg::flag_pf])
         r.flags[alu_pkg::flag_pf] = ~^r.result[7:0];   // even parity, low byte
      return r;
   endfunction

   task automatic check_word(input string name, input alu_pkg::alu_word_t exp,
                             input alu_pkg::alu_word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flags(input string name, input alu_pkg::eflags_t exp,
                              input alu_pkg::eflags_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // drive at edge+1, result is due one edge after the next
   task automatic run_op(input string name, input alu_pkg::alu_op_e op,
         input alu_pkg::opsize_e sz, input alu_pkg::alu_word_t av,
         input alu_pkg::alu_word_t bv, input alu_pkg::eflags_t fv);
      alu_op    = op;
      opsize    = sz;
      a         = av;
      b         = bv;
      eflags_in = fv;
      exp_q.push_back(alu_model(op, sz, av, bv, fv));
      name_q.push_back(name);
      @(posedge clk);
      #1;
   endtask

   // compare one cycle after sampling, at the stable negedge
   always begin
      @(posedge clk);
      due = exp_q.size();   // op sampled on this edge
      @(negedge clk);
      if (due > 0) begin
         exp_r    = exp_q.pop_front();
         cur_name = name_q.pop_front();
         check_word(cur_name, exp_r.result, alu_out);
         check_flags({cur_name, " flags"}, exp_r.flags, eflags_out);
         check_flags({cur_name, " mask"}, exp_r.mask, set_eflags);
      end
   end

   initial begin
      while (cycle < cycle_limit) begin
         @(posedge clk);
         cycle++;
      end
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      op_list   = '{alu_pkg::alu_pass, alu_pkg::alu_add, alu_pkg::alu_and, alu_pkg::alu_mov,
                    alu_pkg::alu_cmovc, alu_pkg::alu_not, alu_pkg::alu_or, alu_pkg::alu_paddw,
                    alu_pkg::alu_paddd, alu_pkg::alu_pmaxsw, alu_pkg::alu_sal,
                    alu_pkg::alu_sar, alu_pkg::alu_pminsw};
      size_list = '{alu_pkg::ops_8, alu_pkg::ops_16, alu_pkg::ops_32};
      clk = 0;
      rst_n = 0;
      a = 64'h7f;
      b = 64'h01;
      eflags_in = '0;
      opsize = alu_pkg::ops_8;
      alu_op = alu_pkg::alu_add;   // nonzero op held through reset
      repeat (10) @(posedge clk);
      #1 rst_n = 1;
      @(negedge clk);   // still zero, nothing sampled yet
      check_word("reset out", '0, alu_out);
      check_flags("reset flags", '0, eflags_out);
      check_flags("reset mask", '0, set_eflags);
      @(posedge clk);
      #1;
      // add edge cases per size
      run_op("add8 of", alu_pkg::alu_add, alu_pkg::ops_8, 64'h7f, 64'h01, '0);
      run_op("add8 cf zero", alu_pkg::alu_add, alu_pkg::ops_8, 64'hff, 64'h01, '0);
      run_op("add8 af", alu_pkg::alu_add, alu_pkg::ops_8, 64'hffff_ff0f, 64'h01, '0);
      run_op("add16 of", alu_pkg::alu_add, alu_pkg::ops_16, 64'h7fff, 64'h0001, '0);
      run_op("add16 cf zero", alu_pkg::alu_add, alu_pkg::ops_16, 64'hffff, 64'h0001, '0);
      run_op("add16 af", alu_pkg::alu_add, alu_pkg::ops_16, 64'h0008, 64'h0008, '0);
      run_op("add32 of", alu_pkg::alu_add, alu_pkg::ops_32, 64'h7fff_ffff, 64'h1, '0);
      run_op("add32 cf zero", alu_pkg::alu_add, alu_pkg::ops_32, 64'hffff_ffff, 64'h1, '0);
      run_op("add32 neg of", alu_pkg::alu_add, alu_pkg::ops_32, 64'h8000_0000, 64'h8000_0000, '0);
      for (int s = 0; s < 3; s++) begin
         run_op("add rand", alu_pkg::alu_add, size_list[s], {$random(seed), $random(seed)},
                {$random(seed), $random(seed)}, '0);
         run_op("and", alu_pkg::alu_and, size_list[s], 64'hffff_0000_a5a5_f0f0,
                64'hdead_beef_ff0f_8f00, '1);
         run_op("or", alu_pkg::alu_or, size_list[s], 64'h1234_5678_0000_8000,
                64'h8765_4321_0000_0000, '0);
         run_op("and zero", alu_pkg::alu_and, size_list[s], 64'hffff_ffff_0000_0000,
                64'hffff_ffff_ffff_ffff, '0);
         run_op("not", alu_pkg::alu_not, size_list[s], 64'hf0f0_f0f0_1234_5678, '0, '0);
      end
      // moves, cf clear then set
      run_op("pass", alu_pkg::alu_pass, alu_pkg::ops_32, 64'h0123_4567_89ab_cdef, 64'h5, '0);
      run_op("mov", alu_pkg::alu_mov, alu_pkg::ops_8, 64'h1, 64'hfedc_ba98_7654_3210, '1);
      run_op("cmovc cf0", alu_pkg::alu_cmovc, alu_pkg::ops_32, 64'haaaa, 64'hbbbb, 6'b111101);
      run_op("cmovc cf1", alu_pkg::alu_cmovc, alu_pkg::ops_32, 64'haaaa, 64'hbbbb, 6'b000010);
      // shift counts 0, 1, 31 and masked ones
      run_op("sal 0", alu_pkg::alu_sal, alu_pkg::ops_32, 64'hffff_0000_8000_0001, 64'd0, '0);
      run_op("sal 1 of", alu_pkg::alu_sal, alu_pkg::ops_32, 64'h4000_0000, 64'd1, '0);
      run_op("sal 1", alu_pkg::alu_sal, alu_pkg::ops_32, 64'hc000_0001, 64'd1, '0);
      run_op("sal 31", alu_pkg::alu_sal, alu_pkg::ops_32, 64'h3, 64'd31, '0);
      run_op("sal 33", alu_pkg::alu_sal, alu_pkg::ops_32, 64'h8000_0000, 64'd33, '0);
      run_op("sar 32", alu_pkg::alu_sar, alu_pkg::ops_32, 64'h8000_0000, 64'd32, '0);
      run_op("sar 1", alu_pkg::alu_sar, alu_pkg::ops_32, 64'h8000_0001, 64'd1, '0);
      run_op("sar 31", alu_pkg::alu_sar, alu_pkg::ops_32, 64'h8000_0000, 64'd31, '0);
      run_op("sar 63", alu_pkg::alu_sar, alu_pkg::ops_32, 64'h7fff_ffff, 64'd63, '0);
      run_op("sar rand", alu_pkg::alu_sar, alu_pkg::ops_32, {$random(seed), $random(seed)},
             {$random(seed), $random(seed)}, '0);
      // packed, wraparound and negative lanes
      run_op("paddw", alu_pkg::alu_paddw, alu_pkg::ops_8, 64'h7fff_8000_ffff_0001,
             64'h0001_8000_0001_ffff, '0);
      run_op("paddd", alu_pkg::alu_paddd, alu_pkg::ops_8, 64'hffff_ffff_7fff_ffff,
             64'h0000_0002_0000_0001, '0);
      run_op("pmaxsw", alu_pkg::alu_pmaxsw, alu_pkg::ops_8, 64'h8000_7fff_fffe_0001,
             64'h7fff_8000_ffff_0001, '0);
      run_op("pminsw", alu_pkg::alu_pminsw, alu_pkg::ops_8, 64'h8000_7fff_fffe_0001,
             64'h7fff_8000_ffff_0001, '0);
      // back-to-back random mix
      for (int i = 0; i < 2000; i++) begin
         run_op($sformatf("rand %0d", i), op_list[{$random(seed)} % 13],
                size_list[{$random(seed)} % 3], {$random(seed), $random(seed)},
                {$random(seed), $random(seed)}, $random(seed));
      end
      while (exp_q.size() != 0) @(negedge clk);   // drain the last result
      @(posedge clk);
      @(negedge clk);   // last assertion attempts have reported
      errors += x86_alu_i.props_i.fail_n;
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== sources.f ====
design/alu_pkg.sv
design/alu_operand_if.sv
design/alu_scalar_unit.sv
design/alu_shift_unit.sv
design/alu_packed_unit.sv
design/alu_result_stage.sv
design/x86_alu.sv
sim/x86_alu_properties.sv
sim/x86_alu_tb.sv
